// ==== hdl/rv_core_pkg.sv ====
// shared widths, RV32I encodings and stage types, imported by every execute-slice block
`default_nettype none

package rv_core_pkg;

    localparam int XLEN       = 32;
    localparam int RegAddrBus = 5;

    // major opcodes
    localparam logic [6:0] INST_TYPE_I   = 7'b0010011;
    localparam logic [6:0] INST_TYPE_R_M = 7'b0110011;
    localparam logic [6:0] INST_TYPE_L   = 7'b0000011;
    localparam logic [6:0] INST_TYPE_S   = 7'b0100011;
    localparam logic [6:0] INST_TYPE_B   = 7'b1100011;
    localparam logic [6:0] INST_JAL      = 7'b1101111;
    localparam logic [6:0] INST_JALR     = 7'b1100111;
    localparam logic [6:0] INST_LUI      = 7'b0110111;
    localparam logic [6:0] INST_AUIPC    = 7'b0010111;
    localparam logic [6:0] INST_NOP_OP   = 7'b0000001;
    localparam logic [6:0] INST_FENCE    = 7'b0001111;
    localparam logic [6:0] INST_CSR      = 7'b1110011;

    // funct3, immediate alu group
    localparam logic [2:0] INST_ADDI  = 3'b000;
    localparam logic [2:0] INST_SLTI  = 3'b010;
    localparam logic [2:0] INST_SLTIU = 3'b011;
    localparam logic [2:0] INST_XORI  = 3'b100;
    localparam logic [2:0] INST_ORI   = 3'b110;
    localparam logic [2:0] INST_ANDI  = 3'b111;
    localparam logic [2:0] INST_SLLI  = 3'b001;
    localparam logic [2:0] INST_SRI   = 3'b101;

    // funct3, register alu group
    localparam logic [2:0] INST_ADD_SUB = 3'b000;
    localparam logic [2:0] INST_SLL     = 3'b001;
    localparam logic [2:0] INST_SLT     = 3'b010;
    localparam logic [2:0] INST_SLTU    = 3'b011;
    localparam logic [2:0] INST_XOR     = 3'b100;
    localparam logic [2:0] INST_SR      = 3'b101;
    localparam logic [2:0] INST_OR      = 3'b110;
    localparam logic [2:0] INST_AND     = 3'b111;

    // funct3, branches
    localparam logic [2:0] INST_BEQ  = 3'b000;
    localparam logic [2:0] INST_BNE  = 3'b001;
    localparam logic [2:0] INST_BLT  = 3'b100;
    localparam logic [2:0] INST_BGE  = 3'b101;
    localparam logic [2:0] INST_BLTU = 3'b110;
    localparam logic [2:0] INST_BGEU = 3'b111;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm20;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    // one instruction word, viewed through the format its opcode selects
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } inst_u;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS
    } alu_op_e;

    typedef enum logic [2:0] {
        BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU, BR_ALWAYS
    } branch_e;

    typedef struct packed {
        logic            valid;
        inst_u           inst;
        logic [XLEN-1:0] addr;
    } fetch_t;

    typedef struct packed {
        logic                  valid;
        logic                  reg_we;
        logic [RegAddrBus-1:0] rd;
        alu_op_e               alu_op;
        logic [XLEN-1:0]       op1;
        logic [XLEN-1:0]       op2;
        branch_e               branch;
        logic [XLEN-1:0]       op1_jump;  // jump base
        logic [XLEN-1:0]       op2_jump;  // jump offset
    } dec_t;

    typedef struct packed {
        logic                  valid;
        logic                  we;
        logic [RegAddrBus-1:0] rd;
        logic [XLEN-1:0]       wdata;
        logic                  jump;
        logic [XLEN-1:0]       jump_addr;
    } ex_result_t;

endpackage

`default_nettype wire

// ==== hdl/if_id.sv ====
// input stage, registers each instruction strobe with its address for the decoder
`default_nettype none
`timescale 1ns/10ps

module if_id
    import rv_core_pkg::*;
(
    input  logic            clk_i,
    input  logic            arst_n_i,
    input  inst_u           inst_i,
    input  logic [XLEN-1:0] inst_addr_i,
    input  logic            inst_valid_i,
    input  logic            jump_i,       // taken jump reported by ex
    output fetch_t          fetch_o
);

    logic            valid_q;
    inst_u           inst_q;
    logic [XLEN-1:0] addr_q;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= inst_valid_i & ~jump_i;  // shadow instruction is dropped
        end
    end

    always_ff @(posedge clk_i) begin
        inst_q <= inst_i;
        addr_q <= inst_addr_i;
    end

    assign fetch_o = '{valid: valid_q, inst: inst_q, addr: addr_q};

endmodule

`default_nettype wire

// ==== hdl/id.sv ====
// combinational decoder, turns the held instruction into register reads and execute operands
`default_nettype none
`timescale 1ns/10ps

module id
    import rv_core_pkg::*;
(
    input  fetch_t                fetch_i,
    input  logic [XLEN-1:0]       reg1_rdata_i,
    input  logic [XLEN-1:0]       reg2_rdata_i,
    output logic [RegAddrBus-1:0] reg1_raddr_o,
    output logic [RegAddrBus-1:0] reg2_raddr_o,
    output dec_t                  dec_o
);

    inst_u           inst;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] link;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] imm_j;
    logic            alt_ok;
    logic            f7_ok;

    function automatic alu_op_e alu_sel(input logic [2:0] funct3, input logic alt);
        case (funct3)
            INST_ADD_SUB: return alt ? ALU_SUB : ALU_ADD;
            INST_SLL:     return ALU_SLL;
            INST_SLT:     return ALU_SLT;
            INST_SLTU:    return ALU_SLTU;
            INST_XOR:     return ALU_XOR;
            INST_SR:      return alt ? ALU_SRA : ALU_SRL;
            INST_OR:      return ALU_OR;
            INST_AND:     return ALU_AND;
            default:      return ALU_ADD;
        endcase
    endfunction

    assign inst = fetch_i.inst;
    assign pc   = fetch_i.addr;
    assign link = pc + 32'd4;

    assign imm_i = {{20{inst.i.imm12[11]}}, inst.i.imm12};
    assign imm_b = {{20{inst.b.imm12}}, inst.b.imm11, inst.b.imm10_5, inst.b.imm4_1, 1'b0};
    assign imm_u = {inst.u.imm20, 12'b0};
    assign imm_j = {{12{inst.j.imm20}}, inst.j.imm19_12, inst.j.imm11, inst.j.imm10_1, 1'b0};

    // funct7 = 0100000 only selects sub and the arithmetic shift
    assign alt_ok = (inst.r.funct3 == INST_SR) ||
                    (inst.r.opcode == INST_TYPE_R_M && inst.r.funct3 == INST_ADD_SUB);
    assign f7_ok  = (inst.r.funct7 == 7'b0000000) || (inst.r.funct7 == 7'b0100000 && alt_ok);

    always_comb begin
        reg1_raddr_o  = '0;
        reg2_raddr_o  = '0;
        dec_o         = '0;
        dec_o.valid   = fetch_i.valid;
        dec_o.rd      = inst.r.rd;
        dec_o.alu_op  = ALU_ADD;
        dec_o.branch  = BR_NONE;

        case (inst.r.opcode)
            INST_TYPE_I: begin
                reg1_raddr_o = inst.i.rs1;
                dec_o.op1    = reg1_rdata_i;
                dec_o.op2    = imm_i;
                case (inst.i.funct3)
                    INST_ADDI, INST_SLTI, INST_SLTIU, INST_XORI, INST_ORI, INST_ANDI: begin
                        dec_o.reg_we = 1'b1;
                        dec_o.alu_op = alu_sel(inst.i.funct3, 1'b0);
                    end
                    INST_SLLI, INST_SRI: begin
                        dec_o.reg_we = f7_ok;  // shamt upper bits must be clean
                        dec_o.alu_op = alu_sel(inst.i.funct3, inst.r.funct7[5]);
                    end
                    default: ;
                endcase
            end
            INST_TYPE_R_M: begin
                reg1_raddr_o = inst.r.rs1;
                reg2_raddr_o = inst.r.rs2;
                dec_o.op1    = reg1_rdata_i;
                dec_o.op2    = reg2_rdata_i;
                dec_o.reg_we = f7_ok;  // mul/div land here with no write
                dec_o.alu_op = alu_sel(inst.r.funct3, inst.r.funct7[5]);
            end
            INST_TYPE_B: begin
                reg1_raddr_o   = inst.b.rs1;
                reg2_raddr_o   = inst.b.rs2;
                dec_o.op1      = reg1_rdata_i;
                dec_o.op2      = reg2_rdata_i;
                dec_o.op1_jump = pc;
                dec_o.op2_jump = imm_b;
                case (inst.b.funct3)
                    INST_BEQ:  dec_o.branch = BR_EQ;
                    INST_BNE:  dec_o.branch = BR_NE;
                    INST_BLT:  dec_o.branch = BR_LT;
                    INST_BGE:  dec_o.branch = BR_GE;
                    INST_BLTU: dec_o.branch = BR_LTU;
                    INST_BGEU: dec_o.branch = BR_GEU;
                    default:   dec_o.branch = BR_NONE;
                endcase
            end
            INST_JAL: begin
                dec_o.reg_we   = 1'b1;
                dec_o.alu_op   = ALU_PASS;
                dec_o.op2      = link;
                dec_o.branch   = BR_ALWAYS;
                dec_o.op1_jump = pc;
                dec_o.op2_jump = imm_j;
            end
            INST_JALR: begin
                reg1_raddr_o   = inst.i.rs1;
                dec_o.reg_we   = 1'b1;
                dec_o.alu_op   = ALU_PASS;
                dec_o.op1      = reg1_rdata_i;
                dec_o.op2      = link;
                dec_o.branch   = BR_ALWAYS;
                dec_o.op1_jump = reg1_rdata_i;  // bypassed in ex like op1
                dec_o.op2_jump = imm_i;
            end
            INST_LUI: begin
                dec_o.reg_we = 1'b1;
                dec_o.alu_op = ALU_PASS;
                dec_o.op2    = imm_u;
            end
            INST_AUIPC: begin
                dec_o.reg_we = 1'b1;
                dec_o.op1    = pc;
                dec_o.op2    = imm_u;
            end
            INST_TYPE_L, INST_TYPE_S, INST_CSR, INST_NOP_OP, INST_FENCE: ;  // retire, no write
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/regs.sv ====
// general register file, 32 x 32 with two combinational reads and one clocked write
`default_nettype none
`timescale 1ns/10ps

module regs
    import rv_core_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  arst_n_i,
    input  logic                  we_i,
    input  logic [RegAddrBus-1:0] waddr_i,
    input  logic [XLEN-1:0]       wdata_i,
    input  logic [RegAddrBus-1:0] raddr1_i,
    input  logic [RegAddrBus-1:0] raddr2_i,
    output logic [XLEN-1:0]       rdata1_o,
    output logic [XLEN-1:0]       rdata2_o
);

    logic [XLEN-1:0] regs_q [2**RegAddrBus];

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < 2**RegAddrBus; i++) begin
                regs_q[i] <= '0;
            end
        end else if (we_i && (waddr_i != '0)) begin  // x0 is never written
            regs_q[waddr_i] <= wdata_i;
        end
    end

    assign rdata1_o = (raddr1_i == '0) ? '0 : regs_q[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 : regs_q[raddr2_i];

endmodule

`default_nettype wire

// ==== hdl/ex.sv ====
// execute stage, alu and branch resolution with a registered result that also feeds writeback
`default_nettype none
`timescale 1ns/10ps

module ex
    import rv_core_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  arst_n_i,
    input  dec_t                  dec_i,
    input  logic [RegAddrBus-1:0] reg1_raddr_i,
    input  logic [RegAddrBus-1:0] reg2_raddr_i,
    output ex_result_t            result_o,
    output logic                  jump_o
);

    logic                  valid_q;
    logic                  we_q;
    logic                  jump_q;
    logic [RegAddrBus-1:0] rd_q;
    logic [XLEN-1:0]       wdata_q;
    logic [XLEN-1:0]       jump_addr_q;

    logic            hit1;
    logic            hit2;
    logic [XLEN-1:0] op1;
    logic [XLEN-1:0] op2;
    logic [XLEN-1:0] jbase;
    logic [XLEN-1:0] target;
    logic [XLEN-1:0] alu_res;
    logic            taken;

    // pending write lands only at the end of this cycle, so forward it
    assign hit1 = we_q && (reg1_raddr_i != '0) && (reg1_raddr_i == rd_q);
    assign hit2 = we_q && (reg2_raddr_i != '0) && (reg2_raddr_i == rd_q);

    assign op1   = hit1 ? wdata_q : dec_i.op1;
    assign op2   = hit2 ? wdata_q : dec_i.op2;
    assign jbase = (hit1 && dec_i.branch == BR_ALWAYS) ? wdata_q : dec_i.op1_jump;  // jalr base

    always_comb begin
        case (dec_i.alu_op)
            ALU_ADD:  alu_res = op1 + op2;
            ALU_SUB:  alu_res = op1 - op2;
            ALU_SLL:  alu_res = op1 << op2[4:0];
            ALU_SLT:  alu_res = {{(XLEN-1){1'b0}}, $signed(op1) < $signed(op2)};
            ALU_SLTU: alu_res = {{(XLEN-1){1'b0}}, op1 < op2};
            ALU_XOR:  alu_res = op1 ^ op2;
            ALU_SRL:  alu_res = op1 >> op2[4:0];
            ALU_SRA:  alu_res = $unsigned($signed(op1) >>> op2[4:0]);
            ALU_OR:   alu_res = op1 | op2;
            ALU_AND:  alu_res = op1 & op2;
            ALU_PASS: alu_res = op2;  // link address or lui value
            default:  alu_res = '0;
        endcase
    end

    always_comb begin
        case (dec_i.branch)
            BR_EQ:     taken = (op1 == op2);
            BR_NE:     taken = (op1 != op2);
            BR_LT:     taken = ($signed(op1) < $signed(op2));
            BR_GE:     taken = ($signed(op1) >= $signed(op2));
            BR_LTU:    taken = (op1 < op2);
            BR_GEU:    taken = (op1 >= op2);
            BR_ALWAYS: taken = 1'b1;
            default:   taken = 1'b0;
        endcase
    end

    assign target = jbase + dec_i.op2_jump;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= 1'b0;
            we_q    <= 1'b0;
            jump_q  <= 1'b0;
        end else begin
            valid_q <= dec_i.valid;
            we_q    <= dec_i.valid & dec_i.reg_we;
            jump_q  <= dec_i.valid & taken;
        end
    end

    always_ff @(posedge clk_i) begin
        rd_q    <= dec_i.rd;
        wdata_q <= alu_res;
        // jal targets are even already, so only jalr is affected
        jump_addr_q <= (dec_i.branch == BR_ALWAYS) ? {target[XLEN-1:1], 1'b0} : target;
    end

    assign result_o = '{valid:     valid_q,
                        we:        we_q,
                        rd:        rd_q,
                        wdata:     wdata_q,
                        jump:      jump_q,
                        jump_addr: jump_addr_q};
    assign jump_o   = jump_q;

endmodule

`default_nettype wire

// ==== hdl/rv_exec_top.sv ====
// execute slice top level, connects input stage, decoder, register file and execute stage
`default_nettype none
`timescale 1ns/10ps

module rv_exec_top
    import rv_core_pkg::*;
(
    input  logic            clk_i,
    input  logic            arst_n_i,
    input  inst_u           inst_i,
    input  logic [XLEN-1:0] inst_addr_i,
    input  logic            inst_valid_i,
    output ex_result_t      result_o
);

    fetch_t                fetch;
    dec_t                  dec;
    logic [RegAddrBus-1:0] reg1_raddr;
    logic [RegAddrBus-1:0] reg2_raddr;
    logic [XLEN-1:0]       reg1_rdata;
    logic [XLEN-1:0]       reg2_rdata;
    logic                  jump;

    if_id if_id_i (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .inst_i       (inst_i),
        .inst_addr_i  (inst_addr_i),
        .inst_valid_i (inst_valid_i),
        .jump_i       (jump),
        .fetch_o      (fetch)
    );

    id id_i (
        .fetch_i      (fetch),
        .reg1_rdata_i (reg1_rdata),
        .reg2_rdata_i (reg2_rdata),
        .reg1_raddr_o (reg1_raddr),
        .reg2_raddr_o (reg2_raddr),
        .dec_o        (dec)
    );

    regs regs_i (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .we_i     (result_o.we),     // writeback from the registered result
        .waddr_i  (result_o.rd),
        .wdata_i  (result_o.wdata),
        .raddr1_i (reg1_raddr),
        .raddr2_i (reg2_raddr),
        .rdata1_o (reg1_rdata),
        .rdata2_o (reg2_rdata)
    );

    ex ex_i (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .dec_i        (dec),
        .reg1_raddr_i (reg1_raddr),
        .reg2_raddr_i (reg2_raddr),
        .result_o     (result_o),
        .jump_o       (jump)
    );

endmodule

`default_nettype wire

// ==== tb/rv_exec_sva.sv ====
// bound assertions on the execute slice result and jump outputs, attached to rv_exec_top
`default_nettype none
`timescale 1ns/10ps

module rv_exec_sva
    import rv_core_pkg::*;
(
    input logic       clk_i,
    input logic       arst_n_i,
    input logic       inst_valid_i,
    input ex_result_t result_o
);

    // outputs held quiet while reset is applied
    quiet_in_reset: assert property (@(posedge clk_i)
        !arst_n_i |-> (!result_o.valid && !result_o.jump))
        else $error("result strobe or jump high during reset");

    // the strobe taken with the jump never comes back as a result
    jump_drops_shadow: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        result_o.jump |-> result_o.valid ##2 !result_o.valid)
        else $error("jump without result strobe or with a retired shadow");

    // a strobe outside the jump shadow retires two cycles later
    strobe_retires: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (inst_valid_i && !result_o.jump) |-> ##2 result_o.valid)
        else $error("instruction strobe produced no result");

endmodule

bind rv_exec_top rv_exec_sva sva_i (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .inst_valid_i (inst_valid_i),
    .result_o     (result_o)
);

`default_nettype wire

// ==== tb/tb_rv_exec.sv ====
// directed testbench for the execute slice, checks every result strobe against an rv32i model
`default_nettype none
`timescale 1ns/10ps

module tb_rv_exec
    import rv_core_pkg::*;
();

    localparam int N_INST = 200;  // upper bound on issued instructions

    logic        clk_i;
    logic        arst_n_i;
    inst_u       inst_i;
    logic [31:0] inst_addr_i;
    logic        inst_valid_i;
    ex_result_t  result_o;

    logic [31:0] seed;
    logic [31:0] mreg [32];
    logic [31:0] pc;
    int          cyc;
    int          value_errs;
    int          strobe_errs;
    ex_result_t  exp_q [$];
    int          due_q [$];
    logic [31:0] addr_q [$];

    rv_exec_top rv_exec_top_i (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .inst_i       (inst_i),
        .inst_addr_i  (inst_addr_i),
        .inst_valid_i (inst_valid_i),
        .result_o     (result_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    initial begin
        #((N_INST * 4 + 100) * 10);
        $display("timeout, the tests did not finish in time");
        $display("Something failed");
        $finish;
    end

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [6:0] op);
        return {f7, rs2, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
    endfunction

    // rv32i reference, updates the model registers in program order
    function automatic ex_result_t model_exec(input logic [31:0] w, input logic [31:0] a);
        ex_result_t  r;
        logic [31:0] x;
        logic [31:0] y;
        logic [31:0] immi;
        logic [31:0] immb;
        logic [31:0] immj;
        logic [31:0] immu;
        logic [6:0]  f7;
        logic [2:0]  f3;
        x    = mreg[w[19:15]];
        y    = mreg[w[24:20]];
        f7   = w[31:25];
        f3   = w[14:12];
        immi = {{20{w[31]}}, w[31:20]};
        immb = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        immj = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        immu = {w[31:12], 12'h000};
        r       = '0;
        r.valid = 1'b1;
        r.rd    = w[11:7];
        if (w[6:0] == 7'h13 || (w[6:0] == 7'h33 && (f7 == 7'h00 || f7 == 7'h20))) begin
            if (w[6:0] == 7'h13) begin
                y = immi;
            end
            r.we = 1'b1;
            case (f3)
                3'd0: r.wdata = (w[6:0] == 7'h33 && f7 == 7'h20) ? x - y : x + y;
                3'd1: r.wdata = x << y[4:0];
                3'd2: r.wdata = ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
                3'd3: r.wdata = (x < y) ? 32'd1 : 32'd0;
                3'd4: r.wdata = x ^ y;
                3'd5: r.wdata = f7[5] ? $unsigned($signed(x) >>> y[4:0]) : x >> y[4:0];
                3'd6: r.wdata = x | y;
                default: r.wdata = x & y;
            endcase
            if ((f3 == 3'd1 && f7 != 7'h00) || (f3 == 3'd5 && f7 != 7'h00 && f7 != 7'h20) ||
                (w[6:0] == 7'h33 && f7 == 7'h20 && f3 != 3'd0 && f3 != 3'd5)) begin
                r.we = 1'b0;
            end
        end else if (w[6:0] == 7'h37 || w[6:0] == 7'h17) begin
            r.we    = 1'b1;
            r.wdata = (w[6:0] == 7'h37) ? immu : a + immu;
        end else if (w[6:0] == 7'h63) begin
            case (f3)
                3'd0: r.jump = (x == y);
                3'd1: r.jump = (x != y);
                3'd4: r.jump = ($signed(x) < $signed(y));
                3'd5: r.jump = ($signed(x) >= $signed(y));
                3'd6: r.jump = (x < y);
                3'd7: r.jump = (x >= y);
                default: r.jump = 1'b0;
            endcase
            r.jump_addr = a + immb;
        end else if (w[6:0] == 7'h6f || w[6:0] == 7'h67) begin
            r.we        = 1'b1;
            r.wdata     = a + 32'd4;
            r.jump      = 1'b1;
            r.jump_addr = (w[6:0] == 7'h6f) ? a + immj : (x + immi) & 32'hffff_fffe;
        end
        if (r.we && r.rd != 5'd0) begin
            mreg[r.rd] = r.wdata;
        end
        return r;
    endfunction

    task automatic check_wb(input ex_result_t exp, input ex_result_t got);
        if (got.we !== exp.we) begin
            $display("[ERROR] result_o.we expected %h got %h", exp.we, got.we);
            value_errs++;
        end else if (exp.we && (got.rd !== exp.rd || got.wdata !== exp.wdata)) begin
            $display("[ERROR] result_o.rd/wdata expected %h/%h got %h/%h",
                     exp.rd, exp.wdata, got.rd, got.wdata);
            value_errs++;
        end
    endtask

    task automatic check_jump(input ex_result_t exp, input ex_result_t got);
        if (got.jump !== exp.jump) begin
            $display("[ERROR] result_o.jump expected %h got %h", exp.jump, got.jump);
            value_errs++;
        end else if (exp.jump && got.jump_addr !== exp.jump_addr) begin
            $display("[ERROR] result_o.jump_addr expected %h got %h",
                     exp.jump_addr, got.jump_addr);
            value_errs++;
        end
    endtask

    always @(posedge clk_i) begin
        cyc <= cyc + 1;
    end

    always @(negedge clk_i) begin
        if (arst_n_i) begin
            if (due_q.size() > 0 && due_q[0] == cyc) begin
                if (!result_o.valid) begin
                    $display("no result strobe for the instruction at address %h", addr_q[0]);
                    strobe_errs++;
                end else begin
                    check_wb(exp_q[0], result_o);
                    check_jump(exp_q[0], result_o);
                end
                void'(exp_q.pop_front());
                void'(due_q.pop_front());
                void'(addr_q.pop_front());
            end else if (result_o.valid) begin
                $display("result strobe with no instruction behind it, cycle %0d", cyc);
                strobe_errs++;
            end
        end
    end

    // strobe one instruction, a dropped shadow gets no expectation
    task automatic issue(input logic [31:0] w, input bit expect_result);
        @(posedge clk_i);
        inst_i       <= w;
        inst_addr_i  <= pc;
        inst_valid_i <= 1'b1;
        if (expect_result) begin
            exp_q.push_back(model_exec(w, pc));
            due_q.push_back(cyc + 3);
            addr_q.push_back(pc);
        end
        pc = pc + 32'd4;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk_i);
            inst_valid_i <= 1'b0;
        end
    endtask

    task automatic test_itype();
        logic [31:0] v;
        logic [2:0]  f3s [6];
        f3s = '{3'd0, 3'd2, 3'd3, 3'd4, 3'd6, 3'd7};
        for (int r = 1; r <= 4; r++) begin
            v = next_rand();
            issue({v[31:12], 5'(r), 7'h37}, 1'b1);
            issue(enc_i(v[11:0], 5'(r), 3'd0, 5'(r), 7'h13), 1'b1);
        end
        for (int k = 0; k < 6; k++) begin
            v = next_rand();
            issue(enc_i(v[11:0], 5'(1 + k % 4), f3s[k], 5'(5 + k % 4), 7'h13), 1'b1);
        end
        v = next_rand();
        issue(enc_i({7'h00, v[4:0]}, 5'd1, 3'd1, 5'd5, 7'h13), 1'b1);
        issue(enc_i({7'h00, v[9:5]}, 5'd2, 3'd5, 5'd6, 7'h13), 1'b1);
        issue(enc_i({7'h20, v[14:10]}, 5'd3, 3'd5, 5'd7, 7'h13), 1'b1);
        idle(4);
    endtask

    task automatic test_rtype();
        logic [9:0] ops [10];
        logic [31:0] v;
        ops = '{{7'h00, 3'd0}, {7'h20, 3'd0}, {7'h00, 3'd1}, {7'h00, 3'd2}, {7'h00, 3'd3},
                {7'h00, 3'd4}, {7'h00, 3'd5}, {7'h20, 3'd5}, {7'h00, 3'd6}, {7'h00, 3'd7}};
        for (int k = 0; k < 10; k++) begin
            v = next_rand();
            // each one reads the register the previous one wrote
            if (k % 2 == 0) begin
                issue(enc_r(ops[k][9:3], 5'(1 + v[1:0]), 5'(20 + k), ops[k][2:0], 5'(21 + k),
                            7'h33), 1'b1);
            end else begin
                issue(enc_r(ops[k][9:3], 5'(20 + k), 5'(1 + v[1:0]), ops[k][2:0], 5'(21 + k),
                            7'h33), 1'b1);  // chained value on rs2
            end
        end
        idle(4);
    endtask

    task automatic test_upper();
        logic [31:0] v;
        v = next_rand();
        issue({v[31:12], 5'd8, 7'h37}, 1'b1);
        issue({v[19:0], 5'd9, 7'h17}, 1'b1);
        pc = v & 32'h0fff_fffc;
        issue({v[31:12], 5'd9, 7'h17}, 1'b1);
        issue(enc_i(12'h05a, 5'd1, 3'd0, 5'd0, 7'h13), 1'b1);
        issue(enc_r(7'h00, 5'd1, 5'd0, 3'd0, 5'd10, 7'h33), 1'b1);
        idle(4);
    endtask

    task automatic test_branch();
        logic [2:0]  f3s [6];
        logic [31:0] v;
        f3s = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
        issue({20'h80000, 5'd10, 7'h37}, 1'b1);
        issue(enc_i(12'h001, 5'd0, 3'd0, 5'd11, 7'h13), 1'b1);
        issue(enc_i(12'hfff, 5'd0, 3'd0, 5'd12, 7'h13), 1'b1);
        issue(enc_i(12'h001, 5'd0, 3'd0, 5'd13, 7'h13), 1'b1);
        idle(2);
        for (int k = 0; k < 6; k++) begin
            for (int p = 0; p < 16; p++) begin
                v = next_rand();
                issue(enc_b({v[12:1], 1'b0}, 5'(10 + p % 4), 5'(10 + p / 4), f3s[k]), 1'b1);
                idle(2);  // keeps later strobes clear of the shadow
            end
        end
        idle(2);
    endtask

    task automatic test_jump();
        logic [31:0] v;
        v = next_rand();
        issue(enc_j({v[20:1], 1'b0}, 5'd14), 1'b1);
        idle(1);
        issue(enc_i(12'h07b, 5'd0, 3'd0, 5'd15, 7'h13), 1'b0);  // shadow, dropped
        idle(3);
        issue(enc_i(12'h010, 5'd14, 3'd0, 5'd14, 7'h13), 1'b1);  // jalr base through the bypass
        issue(enc_i(v[31:20] | 12'h001, 5'd14, 3'd0, 5'd16, 7'h67), 1'b1);
        idle(1);
        issue(enc_i(12'h0c8, 5'd0, 3'd0, 5'd15, 7'h13), 1'b0);
        idle(3);
        issue(enc_r(7'h00, 5'd0, 5'd15, 3'd0, 5'd17, 7'h33), 1'b1);
        idle(4);
    endtask

    task automatic test_unsupported();
        issue(enc_i(12'h010, 5'd1, 3'd2, 5'd5, 7'h03), 1'b1);
        issue(enc_r(7'h00, 5'd2, 5'd1, 3'd2, 5'd5, 7'h23), 1'b1);
        issue(enc_i(12'h300, 5'd1, 3'd1, 5'd5, 7'h73), 1'b1);
        issue(enc_r(7'h01, 5'd2, 5'd1, 3'd4, 5'd5, 7'h33), 1'b1);
        issue(32'h0000_0001, 1'b1);  // nop opcode
        issue(32'h0ff0_000f, 1'b1);
        issue(enc_r(7'h00, 5'd0, 5'd5, 3'd0, 5'd18, 7'h33), 1'b1);
        idle(4);
    endtask

    initial begin
        seed         = 32'h1fa5_6ada;
        pc           = 32'h0000_1000;
        cyc          = 0;
        value_errs   = 0;
        strobe_errs  = 0;
        arst_n_i     = 1'b0;
        inst_i       = '0;
        inst_addr_i  = '0;
        inst_valid_i = 1'b0;
        for (int r = 0; r < 32; r++) begin
            mreg[r] = '0;
        end
        repeat (16) @(posedge clk_i);
        arst_n_i <= 1'b1;
        idle(2);
        test_itype();
        test_rtype();
        test_upper();
        test_branch();
        test_jump();
        test_unsupported();
        idle(4);
        if (due_q.size() != 0) begin
            $display("%0d expected results never arrived", due_q.size());
            strobe_errs += due_q.size();
        end
        $display("errors: %0d wrong values, %0d strobe problems", value_errs, strobe_errs);
        if (value_errs == 0 && strobe_errs == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
hdl/rv_core_pkg.sv
hdl/if_id.sv
hdl/id.sv
hdl/regs.sv
hdl/ex.sv
hdl/rv_exec_top.sv
tb/rv_exec_sva.sv
tb/tb_rv_exec.sv

// ==== Makefile ====
TOP = tb_rv_exec
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output and log"

test:
	verilator --binary --timing --assert -f verilog.f --top-module $(TOP) -o V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	@grep -q "Everything OK" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
